//--- design/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sck timing and byte framing
  localparam int SCK_DIV       = 8;  // clk cycles per sck period
  localparam int CS_GAP        = 1;  // sck periods with cs high between bytes
  localparam int BITS_PER_BYTE = 8;

  localparam int SCK_HI_START = SCK_DIV / 4;      // sck high in the middle half
  localparam int SCK_HI_END   = 3 * SCK_DIV / 4;

  localparam int SCK_CNT_W = $clog2(SCK_DIV);
  localparam int BIT_CNT_W = $clog2(BITS_PER_BYTE);
  localparam int GAP_CNT_W = $clog2(CS_GAP + 1);

endpackage

`default_nettype wire

//--- design/disp_pkg.sv
`default_nettype none

package disp_pkg;

  // one byte on the wire plus its dc level
  typedef struct packed {
    logic       dc;    // 0 command, 1 data
    logic [7:0] data;
  } spi_item_t;

  typedef struct packed {
    logic [15:0] color;
    logic [15:0] count;  // pixels, 2 bytes each
  } fill_job_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone register map
  localparam int WB_ADR_W = 3;
  localparam int WB_DAT_W = 16;

  localparam logic [WB_ADR_W-1:0] REG_CMD        = 3'd0;
  localparam logic [WB_ADR_W-1:0] REG_DATA       = 3'd1;
  localparam logic [WB_ADR_W-1:0] REG_FILL_COLOR = 3'd2;
  localparam logic [WB_ADR_W-1:0] REG_FILL_COUNT = 3'd3;  // write starts a job
  localparam logic [WB_ADR_W-1:0] REG_STATUS     = 3'd4;

  localparam int STAT_FULL  = 0;  // status bit positions
  localparam int STAT_EMPTY = 1;
  localparam int STAT_BUSY  = 2;

  localparam int HOST_QUEUE_DEPTH = 8;
  localparam int FILL_QUEUE_DEPTH = 2;

endpackage

`default_nettype wire

//--- design/spi_client_if.sv
`default_nettype none

// per-byte request/ack/done channel
interface spi_client_if;

  logic                req;
  logic                ack;
  logic                done;
  logic                last;  // final byte of a fill run
  disp_pkg::spi_item_t item;

  modport source (
    output req, item, last,
    input  ack, done
  );

  modport arbiter (
    input  req, item, last,
    output ack, done
  );

  modport engine (input req, item, output ack, done);

endinterface

`default_nettype wire

//--- design/sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  T     push_data,
  input  logic pop,
  output T     pop_data,
  output logic full,
  output logic empty
);

  T                           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  assign full     = int'(count) == DEPTH;
  assign empty    = count == '0;
  assign pop_data = mem[rd_ptr];  // head, next entry shows after a pop

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  a_no_overflow:  assert property (@(posedge clk) disable iff (rst) push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> !empty);

endmodule

`default_nettype wire

//--- design/host_wb_regs.sv
`default_nettype none

module host_wb_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [disp_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [disp_pkg::WB_DAT_W-1:0] wb_dat_w,
  output logic [disp_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                          wb_ack,
  spi_client_if.source                  host_ch,
  input  logic                          fill_full,
  output logic                          fill_push,
  output disp_pkg::fill_job_t           fill_job,
  input  logic                          engine_busy,
  output logic                          busy
);
  import disp_pkg::*;

  spi_item_t           q_din;
  spi_item_t           q_head;
  logic                q_push;
  logic                q_full;
  logic                q_empty;
  logic                access;
  logic                wr_host;
  logic                wr_fill;
  logic                wait_done;  // byte handed over, not yet on the wire
  logic [15:0]         fill_color;
  logic [WB_DAT_W-1:0] status;

  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign wr_host = access && wb_we && (wb_adr == REG_CMD || wb_adr == REG_DATA);
  assign wr_fill = access && wb_we && wb_adr == REG_FILL_COUNT;

  assign q_push    = wr_host && !q_full;
  assign q_din     = '{dc: (wb_adr == REG_DATA), data: wb_dat_w[7:0]};
  assign fill_push = wr_fill && !fill_full;
  assign fill_job  = '{color: fill_color, count: wb_dat_w};

  sync_fifo #(
    .T     (disp_pkg::spi_item_t),
    .DEPTH (HOST_QUEUE_DEPTH)
  ) u_host_q (
    .clk       (clk),
    .rst       (rst),
    .push      (q_push),
    .push_data (q_din),
    .pop       (host_ch.ack),
    .pop_data  (q_head),
    .full      (q_full),
    .empty     (q_empty)
  );

  assign host_ch.req  = !q_empty && !wait_done;
  assign host_ch.item = q_head;
  assign host_ch.last = 1'b0;

  assign busy = !q_empty || wait_done || engine_busy;

  always_comb
  begin
    status             = '0;
    status[STAT_FULL]  = q_full;
    status[STAT_EMPTY] = q_empty;
    status[STAT_BUSY]  = busy;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_ack    <= 1'b0;
      wait_done <= 1'b0;
    end
    else
    begin
      // full queue stalls the ack
      wb_ack <= access && !(wr_host && q_full) && !(wr_fill && fill_full);
      if (host_ch.ack)
        wait_done <= 1'b1;
      else if (host_ch.done)
        wait_done <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (access && wb_we && wb_adr == REG_FILL_COLOR)
      fill_color <= wb_dat_w;
    if (access && !wb_we)
      wb_dat_r <= (wb_adr == REG_FILL_COLOR) ? fill_color : status;
  end

  a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb);

endmodule

`default_nettype wire

//--- design/pixel_fill.sv
`default_nettype none

module pixel_fill (
  input  logic                clk,
  input  logic                rst,
  input  logic                fill_push,
  input  disp_pkg::fill_job_t fill_job,
  output logic                fill_full,
  spi_client_if.source        fill_ch,
  output logic                idle
);
  import disp_pkg::*;

  fill_job_t   job_head;
  logic        job_pop;
  logic        job_empty;
  logic        running;
  logic        hi_byte;    // next byte is the colour msb
  logic        wait_done;
  logic [15:0] color;
  logic [15:0] remaining;  // pixels not yet fully handed over

  sync_fifo #(
    .T     (disp_pkg::fill_job_t),
    .DEPTH (FILL_QUEUE_DEPTH)
  ) u_job_q (
    .clk       (clk),
    .rst       (rst),
    .push      (fill_push),
    .push_data (fill_job),
    .pop       (job_pop),
    .pop_data  (job_head),
    .full      (fill_full),
    .empty     (job_empty)
  );

  assign job_pop = !running && !job_empty;
  assign idle    = !running && job_empty;

  assign fill_ch.req  = running && !wait_done;
  assign fill_ch.item = '{dc: 1'b1, data: hi_byte ? color[15:8] : color[7:0]};
  assign fill_ch.last = !hi_byte && remaining == 16'd1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      running   <= 1'b0;
      hi_byte   <= 1'b1;
      wait_done <= 1'b0;
    end
    else
    begin
      if (job_pop)
      begin
        running <= job_head.count != 16'd0;  // empty job is dropped
        hi_byte <= 1'b1;
      end
      if (fill_ch.ack)
      begin
        wait_done <= 1'b1;
        hi_byte   <= !hi_byte;
      end
      if (fill_ch.done)
      begin
        wait_done <= 1'b0;
        if (remaining == 16'd0)
          running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (job_pop)
    begin
      color     <= job_head.color;
      remaining <= job_head.count;
    end
    else if (fill_ch.ack && !hi_byte)
      remaining <= remaining - 16'd1;
  end

endmodule

`default_nettype wire

//--- design/spi_bus_arbiter.sv
`default_nettype none

module spi_bus_arbiter (
  input  logic          clk,
  input  logic          rst,
  spi_client_if.arbiter host_ch,
  spi_client_if.arbiter fill_ch,
  spi_client_if.source  tx_ch
);

  typedef enum logic [1:0] {G_NONE, G_HOST, G_FILL} grant_t;

  grant_t grant;    // engine owner for one host byte or a whole fill run
  grant_t pick;
  grant_t sel;
  logic   rr_fill;  // fill wins the next tie
  logic   last_q;

  always_comb
  begin
    pick = G_NONE;
    if (host_ch.req && fill_ch.req)
      pick = rr_fill ? G_FILL : G_HOST;
    else if (host_ch.req)
      pick = G_HOST;
    else if (fill_ch.req)
      pick = G_FILL;
  end

  assign sel = (grant == G_NONE) ? pick : grant;

  assign tx_ch.req  = (sel == G_HOST && host_ch.req) || (sel == G_FILL && fill_ch.req);
  assign tx_ch.item = (sel == G_FILL) ? fill_ch.item : host_ch.item;
  assign tx_ch.last = (sel == G_FILL) ? fill_ch.last : host_ch.last;

  assign host_ch.ack  = tx_ch.ack && sel == G_HOST;
  assign host_ch.done = tx_ch.done && sel == G_HOST;
  assign fill_ch.ack  = tx_ch.ack && sel == G_FILL;
  assign fill_ch.done = tx_ch.done && sel == G_FILL;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant   <= G_NONE;
      rr_fill <= 1'b0;
      last_q  <= 1'b0;
    end
    else
    begin
      if (tx_ch.ack)
      begin
        grant  <= sel;
        last_q <= tx_ch.last;
      end
      if (tx_ch.done)
      begin
        if (sel == G_HOST)
        begin
          grant   <= G_NONE;  // one byte per host grant
          rr_fill <= 1'b1;
        end
        else if (last_q)
        begin
          grant   <= G_NONE;
          rr_fill <= 1'b0;
        end
      end
    end
  end

  // every engine ack lands on exactly one source
  a_one_ack: assert property (@(posedge clk) disable iff (rst)
    tx_ch.ack |-> $onehot({host_ch.ack, fill_ch.ack}));

  // done only ends a byte that an owner took
  a_grant_held: assert property (@(posedge clk) disable iff (rst)
    tx_ch.done |-> grant != G_NONE);

endmodule

`default_nettype wire

//--- design/spi_byte_tx.sv
`default_nettype none

module spi_byte_tx (
  input  logic         clk,
  input  logic         rst,
  spi_client_if.engine tx_ch,
  output logic         sck,
  output logic         cs,
  output logic         dc,
  output logic         mosi,
  output logic         active
);
  import spi_cfg_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_LEAD, ST_SHIFT} state_t;

  state_t                   state;
  logic [SCK_CNT_W-1:0]     div_cnt;
  logic [BIT_CNT_W-1:0]     bit_cnt;
  logic [GAP_CNT_W-1:0]     gap_cnt;  // cs-high periods still owed
  logic [BITS_PER_BYTE-1:0] shreg;
  logic                     boundary;
  logic                     gap_ok;
  logic                     last_bit;
  logic                     sck_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // period boundaries and sck
  assign boundary = int'(div_cnt) == SCK_DIV - 1;
  assign gap_ok   = int'(gap_cnt) <= 1;  // this boundary closes the gap
  assign last_bit = int'(bit_cnt) == BITS_PER_BYTE - 1;
  assign sck_next = state == ST_SHIFT && int'(div_cnt) >= SCK_HI_START - 1
                    && int'(div_cnt) < SCK_HI_END - 1;

  assign tx_ch.ack  = state == ST_IDLE && boundary && tx_ch.req && gap_ok;
  assign tx_ch.done = state == ST_SHIFT && boundary && last_bit;
  assign active     = state != ST_IDLE || gap_cnt != '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // byte framing
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      gap_cnt <= '0;
      sck     <= 1'b0;
      cs      <= 1'b1;
      dc      <= 1'b0;
      mosi    <= 1'b0;
    end
    else
    begin
      div_cnt <= boundary ? '0 : div_cnt + 1'b1;
      sck     <= sck_next;
      if (boundary)
      begin
        case (state)
          ST_IDLE:
          begin
            if (tx_ch.ack)
            begin
              cs      <= 1'b0;  // one lead period before bit 7
              dc      <= tx_ch.item.dc;
              gap_cnt <= '0;
              state   <= ST_LEAD;
            end
            else if (gap_cnt != '0)
              gap_cnt <= gap_cnt - 1'b1;
          end
          ST_LEAD:
          begin
            mosi    <= shreg[BITS_PER_BYTE-1];
            bit_cnt <= '0;
            state   <= ST_SHIFT;
          end
          ST_SHIFT:
          begin
            if (last_bit)
            begin
              cs      <= 1'b1;
              mosi    <= 1'b0;
              gap_cnt <= GAP_CNT_W'(CS_GAP);
              state   <= ST_IDLE;
            end
            else
            begin
              mosi    <= shreg[BITS_PER_BYTE-1];  // msb first
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (tx_ch.ack)
      shreg <= tx_ch.item.data;
    else if (boundary && (state == ST_LEAD || (state == ST_SHIFT && !last_bit)))
      shreg <= shreg << 1;
  end

  a_sck_idle_low: assert property (@(posedge clk) disable iff (rst) cs |-> !sck);
  a_dc_stable:    assert property (@(posedge clk) disable iff (rst)
    (!cs && !$past(cs)) |-> $stable(dc));

endmodule

`default_nettype wire

//--- design/display_spi_top.sv
`default_nettype none

module display_spi_top (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [disp_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [disp_pkg::WB_DAT_W-1:0] wb_dat_w,
  output logic [disp_pkg::WB_DAT_W-1:0] wb_dat_r,
  output logic                          wb_ack,
  output logic                          sck,
  output logic                          cs,
  output logic                          dc,
  output logic                          mosi,
  output logic                          busy
);
  import disp_pkg::*;

  fill_job_t fill_job;
  logic      fill_push;
  logic      fill_full;
  logic      fill_idle;
  logic      tx_active;

  spi_client_if host_ch ();
  spi_client_if fill_ch ();
  spi_client_if tx_ch ();

  host_wb_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .host_ch     (host_ch.source),
    .fill_full   (fill_full),
    .fill_push   (fill_push),
    .fill_job    (fill_job),
    .engine_busy (tx_active || !fill_idle),  // fill run counts as busy
    .busy        (busy)
  );

  pixel_fill u_fill (
    .clk       (clk),
    .rst       (rst),
    .fill_push (fill_push),
    .fill_job  (fill_job),
    .fill_full (fill_full),
    .fill_ch   (fill_ch.source),
    .idle      (fill_idle)
  );

  spi_bus_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .host_ch (host_ch.arbiter),
    .fill_ch (fill_ch.arbiter),
    .tx_ch   (tx_ch.source)
  );

  spi_byte_tx u_tx (
    .clk    (clk),
    .rst    (rst),
    .tx_ch  (tx_ch.engine),
    .sck    (sck),
    .cs     (cs),
    .dc     (dc),
    .mosi   (mosi),
    .active (tx_active)
  );

endmodule

`default_nettype wire

//--- test/tb_display_spi.sv
`default_nettype none

module tb_display_spi;
  timeunit 1ns;
  timeprecision 100ps;
  import disp_pkg::*;
  import spi_cfg_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int WB_TIMEOUT   = 2000;
  localparam int IDLE_TIMEOUT = 5000;

  localparam logic [1:0] OP_WR   = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_SYNC = 2'd2;  // wait for idle, then check the wire

  typedef struct packed {
    logic [1:0]  op;
    logic [2:0]  adr;
    logic [15:0] val;
    logic [15:0] mask;  // read compare mask
  } step_t;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [2:0]  wb_adr;
  logic [15:0] wb_dat_w;
  logic [15:0] wb_dat_r;
  logic        wb_ack;
  logic        sck;
  logic        cs;
  logic        dc;
  logic        mosi;
  logic        busy;

  int          errors = 0;
  int          timeouts = 0;
  int          nbits = 0;
  time         last_rise = 0;
  logic [7:0]  shift = '0;
  logic [15:0] fill_color = '0;
  logic [8:0]  got_q[$];     // {dc, byte} seen on the wire
  logic [8:0]  host_exp[$];
  logic [8:0]  fill_exp[$];

  step_t steps [18] = '{
    '{OP_RD,   REG_STATUS,     16'(1 << STAT_EMPTY), 16'h0007},
    '{OP_WR,   REG_CMD,        16'h002a, 16'h0000},
    '{OP_WR,   REG_DATA,       16'h0000, 16'h0000},
    '{OP_WR,   REG_DATA,       16'h0081, 16'h0000},
    '{OP_WR,   REG_CMD,        16'h002c, 16'h0000},
    '{OP_SYNC, 3'd0,           16'h0000, 16'h0000},
    '{OP_WR,   REG_FILL_COLOR, 16'hf81f, 16'h0000},
    '{OP_WR,   REG_FILL_COUNT, 16'h0003, 16'h0000},
    '{OP_SYNC, 3'd0,           16'h0000, 16'h0000},
    '{OP_WR,   REG_FILL_COUNT, 16'h0000, 16'h0000},  // empty job
    '{OP_SYNC, 3'd0,           16'h0000, 16'h0000},
    '{OP_WR,   REG_FILL_COLOR, 16'h07e0, 16'h0000},
    '{OP_WR,   REG_FILL_COUNT, 16'h0004, 16'h0000},
    '{OP_WR,   REG_CMD,        16'h0011, 16'h0000},  // host bytes during the run
    '{OP_WR,   REG_DATA,       16'h0022, 16'h0000},
    '{OP_WR,   REG_DATA,       16'h0033, 16'h0000},
    '{OP_SYNC, 3'd0,           16'h0000, 16'h0000},
    '{OP_RD,   REG_STATUS,     16'(1 << STAT_EMPTY), 16'h0007}
  };

  display_spi_top dut0 (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sck      (sck),
    .cs       (cs),
    .dc       (dc),
    .mosi     (mosi),
    .busy     (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("FAIL @%0t: %s (got %h, expected %h)", $time, what, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // spi monitor, mode 0
  always @(posedge sck)
  begin
    check_equal(cs, 1'b0, "sck rose while cs high");
    if (nbits != 0)
      check_equal(32'($time - last_rise), SCK_DIV * CLK_PERIOD, "sck period");
    last_rise = $time;
    shift = {shift[6:0], mosi};
    nbits++;
  end

  always @(posedge cs)
  begin
    if (nbits != 0)  // skips the x to 1 edge at reset
    begin
      check_equal(nbits, BITS_PER_BYTE, "bits in one cs frame");
      check_equal(sck, 1'b0, "sck high when cs rose");
      got_q.push_back({dc, shift});
    end
    nbits = 0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // wishbone master and waits
  task automatic wb_access(input logic we, input logic [2:0] adr, input logic [15:0] wdata,
                           output logic [15:0] rdata);
    int n;
    n = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do
    begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < WB_TIMEOUT);
    if (!wb_ack)
    begin
      $display("timeout: wishbone access to address %0d was never acknowledged", adr);
      timeouts++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end while (busy && n < IDLE_TIMEOUT);
    if (busy)
    begin
      $display("timeout: busy did not return low");
      timeouts++;
    end
    repeat (2) @(negedge clk);
  endtask

  // fill block inserted at host position p must rebuild the wire stream
  function automatic bit split_matches(int p);
    int nf;
    int i;
    nf = fill_exp.size();
    for (i = 0; i < got_q.size(); i++)
    begin
      if (i < p)
      begin
        if (got_q[i] != host_exp[i])
          return 1'b0;
      end
      else if (i < p + nf)
      begin
        if (got_q[i] != fill_exp[i-p])
          return 1'b0;
      end
      else if (got_q[i] != host_exp[i-nf])
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_stream();
    int  p;
    bit  found;
    found = 1'b0;
    check_equal(got_q.size(), host_exp.size() + fill_exp.size(), "byte count on the wire");
    if (got_q.size() == host_exp.size() + fill_exp.size())
    begin
      for (p = 0; p <= host_exp.size(); p++)
      begin
        if (!found && split_matches(p))
          found = 1'b1;
      end
    end
    check_equal(found, 1'b1, "host order or contiguous fill block broken");
    got_q.delete();
    host_exp.delete();
    fill_exp.delete();
  endtask

  task automatic apply_step(input step_t s);
    logic [15:0] rd;
    int          k;
    case (s.op)
      OP_WR:
      begin
        wb_access(1'b1, s.adr, s.val, rd);
        if (s.adr == REG_CMD || s.adr == REG_DATA)
          host_exp.push_back({s.adr == REG_DATA, s.val[7:0]});
        else if (s.adr == REG_FILL_COLOR)
          fill_color = s.val;
        else if (s.adr == REG_FILL_COUNT)
        begin
          for (k = 0; k < int'(s.val); k++)
          begin
            fill_exp.push_back({1'b1, fill_color[15:8]});  // high byte first
            fill_exp.push_back({1'b1, fill_color[7:0]});
          end
        end
      end
      OP_RD:
      begin
        wb_access(1'b0, s.adr, 16'h0000, rd);
        check_equal(rd & s.mask, s.val & s.mask, "register read");
      end
      default:
      begin
        wait_idle();
        check_stream();
      end
    endcase
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    logic [31:0] seed;
    logic [15:0] rd;
    logic [2:0]  adr;
    bit          full_seen;
    int          i;
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    full_seen = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_equal(cs, 1'b1, "cs after reset");
    check_equal(sck, 1'b0, "sck after reset");
    check_equal(busy, 1'b0, "busy after reset");

    for (i = 0; i < 18 && timeouts == 0; i++)
      apply_step(steps[i]);

    // back-pressure burst of random bytes
    seed = 32'h1587;
    for (i = 0; i < HOST_QUEUE_DEPTH + 3 && timeouts == 0; i++)
    begin
      seed = lcg_next(seed);
      adr  = seed[24] ? REG_DATA : REG_CMD;
      apply_step('{OP_WR, adr, {8'h00, seed[23:16]}, 16'h0000});
      wb_access(1'b0, REG_STATUS, 16'h0000, rd);
      if (rd[STAT_FULL])
        full_seen = 1'b1;
    end
    if (timeouts == 0)
    begin
      check_equal(full_seen, 1'b1, "status never showed a full host queue");
      apply_step('{OP_SYNC, 3'd0, 16'h0000, 16'h0000});
    end

    $display("errors: %0d  timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
design/spi_cfg_pkg.sv
design/disp_pkg.sv
design/spi_client_if.sv
design/sync_fifo.sv
design/host_wb_regs.sv
design/pixel_fill.sv
design/spi_bus_arbiter.sv
design/spi_byte_tx.sv
design/display_spi_top.sv
test/tb_display_spi.sv

//--- run.sh
#!/bin/sh
# build and run the display SPI testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f files.f --top-module tb_display_spi -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "=== PASS ===" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
